// ==== dv/prefetcher_chk.sv ====
// ====================
// Handshake and reset assertions bound to the prefetcher top
// ====================
`timescale 1ns/1ps

module prefetcher_chk
    import prefetch_pkg::*;
(
    input logic clk,
    input logic arst_n,
    input logic s_r_valid,
    input logic s_r_ready,
    input r_t   s_r,
    input logic m_ar_valid,
    input logic m_ar_ready,
    input ar_t  m_ar,
    input logic m_aw_valid,
    input logic aw_hold
);

    int fail_cnt = 0;   // Assertion failures so far

    // A stalled beat keeps valid and payload
    assert property (@(posedge clk) disable iff (!arst_n)
        s_r_valid && !s_r_ready |=> s_r_valid && $stable(s_r))
        else begin
            fail_cnt++;
            $error("s_r changed while stalled");
        end

    assert property (@(posedge clk) disable iff (!arst_n)
        m_ar_valid && !m_ar_ready |=> m_ar_valid && $stable(m_ar))
        else begin
            fail_cnt++;
            $error("m_ar changed while stalled");
        end

    assert property (@(posedge clk)
        !arst_n |-> !s_r_valid && !m_ar_valid && !m_aw_valid && !aw_hold)
        else begin
            fail_cnt++;
            $error("valid or aw_hold high during reset");
        end

    // Prefetch data never leaks upstream
    assert property (@(posedge clk) disable iff (!arst_n)
        s_r_valid |-> s_r.id != PF_ID)
        else begin
            fail_cnt++;
            $error("s_r carries the prefetch ID");
        end

endmodule

bind prefetcher_top prefetcher_chk chk_i (
    .clk(clk), .arst_n(arst_n),
    .s_r_valid(s_r_valid), .s_r_ready(s_r_ready), .s_r(s_r),
    .m_ar_valid(m_ar_valid), .m_ar_ready(m_ar_ready), .m_ar(m_ar),
    .m_aw_valid(m_aw_valid), .aw_hold(aw_hold)
);

// ==== dv/prefetcher_tb.sv ====
// ====================
// Prefetcher testbench with APB setup, random reads
// and writes, memory model and prefetch stream checks
// ====================
`timescale 1ns/1ps

module prefetcher_tb
    import prefetch_pkg::*;
;

    localparam int TIMEOUT_CYCLES = 400 * 60;

    typedef struct {
        ar_t req;
        data_t data;
        int  due;
    } mem_rsp_t;

    logic  clk, arst_n;
    logic  psel, penable, pwrite, pready, pslverr;
    addr_t paddr;
    data_t pwdata, prdata;
    logic  s_ar_valid, s_ar_ready, s_r_valid, s_r_ready, s_aw_valid, s_aw_ready;
    ar_t   s_ar;
    r_t    s_r;
    aw_t   s_aw;
    logic  m_ar_valid, m_ar_ready, m_r_valid, m_r_ready, m_aw_valid, m_aw_ready;
    ar_t   m_ar;
    r_t    m_r;
    aw_t   m_aw;

    int       cycle = 0;
    int       version [addr_t];
    mem_rsp_t rsp_q [$];
    bit       bp_en = 0;       // Random back-pressure
    bit       en_model = 0;
    addr_t    win_lo, win_hi;
    int       out_lim_model = QUEUE_DEPTH;
    bit       pf_ok = 0;       // Set once an in-window miss was forwarded
    addr_t    pf_next;
    int       pf_inflight = 0;

    prefetcher_top dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic data_t block_value(input addr_t addr);
        int ver;
        ver = version.exists(addr) ? version[addr] : 0;
        return (addr * 32'h9E3779B1) ^ (data_t'(ver) * 32'h01000193);
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp)
            stop_on_error($sformatf("Fail %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_id(input string name, input id_t got, input id_t exp);
        if (got !== exp)
            stop_on_error($sformatf("Fail %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp)
            stop_on_error($sformatf("Fail %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_reg(input addr_t offs, input data_t got, input data_t exp);
        if (got !== exp)
            stop_on_error($sformatf("Fail prdata at %h got %h expected %h", offs, got, exp));
    endtask

    task automatic apb_access(input logic wr, input addr_t addr, input data_t wdata,
                              output data_t rdata, output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        do @(negedge clk); while (!pready);
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic reg_write(input addr_t addr, input data_t wdata);
        data_t rd;
        logic  err;
        apb_access(1'b1, addr, wdata, rd, err);
        if (err) stop_on_error($sformatf("Unexpected pslverr on write to %h", addr));
    endtask

    task automatic reg_expect(input addr_t addr, input data_t exp);
        data_t rd;
        logic  err;
        apb_access(1'b0, addr, '0, rd, err);
        if (err) stop_on_error($sformatf("Unexpected pslverr on read of %h", addr));
        check_reg(addr, rd, exp);
    endtask

    task automatic set_window(input addr_t lo, input addr_t hi, input int lim, input bit en);
        reg_write(REG_CTRL, 0);
        en_model = 0;
        pf_ok    = 0;
        reg_write(REG_BAR, lo);
        reg_write(REG_LIMIT, hi);
        reg_write(REG_OUT_LIMIT, lim);
        reg_write(REG_CTRL, data_t'(en));
        win_lo        = lo;
        win_hi        = hi;
        out_lim_model = lim;
        en_model      = en;
    endtask

    // One upstream read, expected value taken at issue
    task automatic read_txn(input addr_t addr, input id_t id);
        data_t exp;
        ar_t   req;
        exp = block_value(addr);
        req.addr = addr;
        req.id   = id;
        @(posedge clk);
        s_ar_valid <= 1'b1;
        s_ar       <= req;
        do @(negedge clk); while (!s_ar_ready);
        @(posedge clk);
        s_ar_valid <= 1'b0;
        do @(negedge clk); while (!(s_r_valid && s_r_ready));
        check_data("s_r.data", s_r.data, exp);
        check_id("s_r.id", s_r.id, id);
    endtask

    task automatic write_txn(input addr_t addr, input id_t id);
        aw_t w;
        w.addr = addr;
        w.id   = id;
        @(posedge clk);
        s_aw_valid <= 1'b1;
        s_aw       <= w;
        do @(negedge clk); while (!s_aw_ready);
        if (!m_aw_valid) stop_on_error("s_aw accepted with no m_aw transfer");
        check_addr("m_aw.addr", m_aw.addr, w.addr);
        check_id("m_aw.id", m_aw.id, w.id);
        @(posedge clk);
        s_aw_valid <= 1'b0;
    endtask

    // Memory responder and bus monitor, transfers seen at the falling edge
    always @(negedge clk) begin
        mem_rsp_t rsp;
        if (dut_i.chk_i.fail_cnt != 0)
            stop_on_error("A handshake or reset assertion on the DUT failed");
        if (m_r_valid && m_r_ready) begin
            if (m_r.id == PF_ID) pf_inflight--;
            void'(rsp_q.pop_front());
        end
        if (m_ar_valid && m_ar_ready) begin
            if (m_ar.id == PF_ID) begin
                if (!pf_ok) stop_on_error("Prefetch read issued with no miss stream active");
                check_addr("m_ar.addr", m_ar.addr, pf_next);
                if (m_ar.addr > win_hi) stop_on_error("Prefetch read past the window limit");
                if (pf_inflight + 1 > out_lim_model)
                    stop_on_error("Prefetches in flight exceed the outstanding limit");
                pf_next = pf_next + BLOCK_BYTES;
                pf_inflight++;
            end else if (en_model && m_ar.addr >= win_lo && m_ar.addr <= win_hi) begin
                pf_next = m_ar.addr + BLOCK_BYTES;
                pf_ok   = 1;
            end
            rsp.req  = m_ar;
            rsp.data = block_value(m_ar.addr);
            rsp.due  = cycle + 1 + ($urandom % 4);
            rsp_q.push_back(rsp);
        end
        if (m_aw_valid && m_aw_ready) begin
            version[m_aw.addr] = version.exists(m_aw.addr) ? version[m_aw.addr] + 1 : 1;
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle > TIMEOUT_CYCLES) stop_on_error("Timeout, the run did not complete");
        s_r_ready  <= bp_en ? 1'($urandom % 2) : 1'b1;
        m_ar_ready <= bp_en ? 1'($urandom % 2) : 1'b1;
        if (rsp_q.size() > 0 && cycle >= rsp_q[0].due) begin
            m_r_valid <= 1'b1;
            m_r.data  <= rsp_q[0].data;
            m_r.id    <= rsp_q[0].req.id;
        end else begin
            m_r_valid <= 1'b0;
        end
    end

    initial begin
        data_t rd;
        logic  err;
        addr_t a;
        void'($urandom(5772));
        arst_n     = 1'b0;
        psel       = 0;
        penable    = 0;
        pwrite     = 0;
        paddr      = '0;
        pwdata     = '0;
        s_ar_valid = 0;
        s_ar       = '0;
        s_r_ready  = 1;
        s_aw_valid = 0;
        s_aw       = '0;
        m_ar_ready = 1;
        m_r_valid  = 0;
        m_r        = '0;
        m_aw_ready = 1;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;

        // Register access and clamping
        reg_write(REG_BAR, 32'h1000);
        reg_expect(REG_BAR, 32'h1000);
        reg_write(REG_LIMIT, 32'h10FC);
        reg_expect(REG_LIMIT, 32'h10FC);
        reg_write(REG_OUT_LIMIT, 0);
        reg_expect(REG_OUT_LIMIT, 1);
        reg_write(REG_OUT_LIMIT, 20);
        reg_expect(REG_OUT_LIMIT, QUEUE_DEPTH);
        reg_write(REG_OUT_LIMIT, 3);
        reg_expect(REG_OUT_LIMIT, 3);
        apb_access(1'b1, 32'h10, 32'h5, rd, err);
        if (!err) stop_on_error("No pslverr on unmapped offset");

        // Pass-through with prefetching off, then outside the window
        for (int i = 0; i < 20; i++)
            read_txn(32'h1000 + 4 * ($urandom % 64), id_t'($urandom % 15));
        set_window(32'h1000, 32'h10FC, 4, 1);
        for (int i = 0; i < 20; i++)
            read_txn(32'h2000 + 4 * ($urandom % 64), id_t'($urandom % 15));

        // Sequential stream up to the limit
        for (int i = 0; i < 64; i++) read_txn(32'h1000 + 4 * i, id_t'($urandom % 15));

        // Random in-window reads
        for (int i = 0; i < 60; i++)
            read_txn(32'h1000 + 4 * ($urandom % 64), id_t'($urandom % 15));

        // Writes inside the window flush stale blocks
        for (int i = 0; i < 10; i++) begin
            a = 32'h1000 + 32 * i;
            read_txn(a, id_t'($urandom % 15));
            repeat (3) @(posedge clk);
            write_txn(a + 4, id_t'($urandom % 15));
            read_txn(a + 4, id_t'($urandom % 15));
            read_txn(a + 8, id_t'($urandom % 15));
        end
        write_txn(32'h3000, 4'h2);
        read_txn(32'h3000, 4'h3);

        // Back-pressure on s_r and m_ar
        bp_en = 1;
        for (int i = 0; i < 80; i++) begin
            if (i % 4 == 3) a = 32'h2000 + 4 * ($urandom % 32);
            else if (i % 8 < 4) a = 32'h1000 + 4 * (i % 64);
            else a = 32'h1000 + 4 * ($urandom % 64);
            read_txn(a, id_t'($urandom % 15));
        end
        bp_en = 0;
        repeat (10) @(posedge clk);
        #1;

        if (dut_i.chk_i.fail_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
verilog/prefetch_pkg.sv
verilog/prefetch_regs.sv
verilog/prefetch_queue.sv
verilog/prefetch_ctrl.sv
verilog/prefetcher_top.sv
dv/prefetcher_chk.sv
dv/prefetcher_tb.sv

// ==== verilog/prefetch_ctrl.sv ====
// ====================
// Prefetch controller FSM for hits, miss cleanup,
// demand forwarding and prefetch issue
// ====================
`timescale 1ns/1ps

module prefetch_ctrl
    import prefetch_pkg::*;
(
    input  logic          clk,
    input  logic          arst_n,
    input  prefetch_cfg_t cfg,
    // Upstream read channels
    input  logic          s_ar_valid,
    input  ar_t           s_ar,
    output logic          s_ar_ready,
    output logic          s_r_valid,
    output r_t            s_r,
    input  logic          s_r_ready,
    // Memory read address
    output logic          m_ar_valid,
    output ar_t           m_ar,
    input  logic          m_ar_ready,
    // Write flush handshake
    input  logic          wr_flush,
    output logic          aw_hold,
    // Queue side
    output logic          alloc_valid,
    output addr_t         alloc_addr,
    output logic          pop,
    output logic          flush,
    input  addr_t         head_addr,
    input  logic          head_filled,
    input  data_t         head_data,
    input  cnt_t          allocated,
    input  cnt_t          outstanding
);

    ctrl_state_t state_q;
    ar_t         req_q;         // Demand request kept across cleanup
    r_t          rsp_q;         // Hit response
    ar_t         pf_ar;
    addr_t       pf_addr_q;     // Next block to prefetch
    logic        pf_active_q;   // Cleared by writes and misses
    logic        pf_stall_q;    // Prefetch AR raised but not taken
    logic        pf_want;
    logic        pf_valid;
    logic        req_acc;
    logic        hit;

    assign hit = (s_ar.addr == head_addr) && head_filled;

    // New prefetches yield to a waiting request, a raised one is held
    assign pf_want = (state_q == IDLE) && pf_active_q && cfg.enable && !wr_flush &&
                     (allocated < cfg.out_limit) && (pf_addr_q <= cfg.limit);
    assign pf_valid = pf_stall_q || (pf_want && !s_ar_valid);

    assign s_ar_ready = (state_q == IDLE) && !pf_valid;
    assign req_acc    = s_ar_valid && s_ar_ready;

    assign pf_ar.addr = pf_addr_q;
    assign pf_ar.id   = PF_ID;
    assign m_ar_valid = pf_valid || (state_q == FORWARD);
    assign m_ar       = (state_q == FORWARD) ? req_q : pf_ar;

    assign s_r_valid = (state_q == SERVE);
    assign s_r       = rsp_q;

    assign alloc_valid = pf_valid && m_ar_ready;
    assign alloc_addr  = pf_addr_q;
    assign pop         = req_acc && hit;
    // Disabled queue is kept empty so it never holds data older than a write
    assign flush       = wr_flush || (req_acc && !hit) || !cfg.enable;

    // Write waits until no prefetch read can still return old data
    assign aw_hold = wr_flush && ((outstanding != '0) || pf_stall_q);

    always_ff @(posedge clk) begin
        if (req_acc) begin
            req_q      <= s_ar;
            rsp_q.data <= head_data;
            rsp_q.id   <= s_ar.id;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q     <= IDLE;
            pf_addr_q   <= '0;
            pf_active_q <= 1'b0;
            pf_stall_q  <= 1'b0;
        end else begin
            pf_stall_q <= pf_valid && !m_ar_ready;
            if (alloc_valid) begin
                pf_addr_q <= pf_addr_q + BLOCK_BYTES;
            end
            if (wr_flush) begin
                pf_active_q <= 1'b0;
            end

            case (state_q)
                IDLE: begin
                    if (req_acc) begin
                        if (hit) begin
                            state_q <= SERVE;
                        end else begin
                            state_q     <= CLEANUP;
                            pf_active_q <= 1'b0;
                        end
                    end
                end
                SERVE: begin
                    if (s_r_ready) begin
                        state_q <= IDLE;
                    end
                end
                CLEANUP: begin
                    if (outstanding == '0) begin   // All dropped fills drained
                        state_q <= FORWARD;
                    end
                end
                FORWARD: begin
                    if (m_ar_ready) begin
                        state_q     <= IDLE;
                        pf_addr_q   <= req_q.addr + BLOCK_BYTES;
                        pf_active_q <= !wr_flush;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

endmodule

// ==== verilog/prefetch_pkg.sv ====
// ====================
// Prefetcher package with widths, register map,
// channel payload structs and controller states
// ====================
package prefetch_pkg;

    localparam int ADDR_W      = 32;
    localparam int DATA_W      = 32;
    localparam int ID_W        = 4;
    localparam int QUEUE_DEPTH = 8;   // Power of two, pointers wrap
    localparam int CNT_W       = $clog2(QUEUE_DEPTH + 1);
    localparam int PTR_W       = $clog2(QUEUE_DEPTH);

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ID_W-1:0]   id_t;
    typedef logic [CNT_W-1:0]  cnt_t;
    typedef logic [PTR_W-1:0]  ptr_t;

    localparam addr_t BLOCK_BYTES = 32'd4;   // Step between consecutive blocks

    // Reserved for prefetch reads, upstream IDs stay below it
    localparam id_t PF_ID = '1;

    // APB register offsets
    localparam addr_t REG_BAR       = 32'h0;
    localparam addr_t REG_LIMIT     = 32'h4;   // Last block address in window
    localparam addr_t REG_OUT_LIMIT = 32'h8;
    localparam addr_t REG_CTRL      = 32'hC;   // Bit 0 enable

    typedef struct packed {
        addr_t addr;
        id_t   id;
    } ar_t;

    typedef struct packed {
        data_t data;
        id_t   id;
    } r_t;

    typedef struct packed {
        addr_t addr;
        id_t   id;
    } aw_t;

    typedef struct packed {
        addr_t bar;
        addr_t limit;
        cnt_t  out_limit;   // 1 to QUEUE_DEPTH
        logic  enable;
    } prefetch_cfg_t;

    typedef enum logic [1:0] {
        IDLE,
        SERVE,
        CLEANUP,
        FORWARD
    } ctrl_state_t;

endpackage

// ==== verilog/prefetch_queue.sv ====
// ====================
// Circular queue of prefetched blocks with in-order
// fill, head pop and flush with fill drain
// ====================
`timescale 1ns/1ps

module prefetch_queue
    import prefetch_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    input  logic  alloc_valid,
    input  addr_t alloc_addr,
    input  logic  fill_valid,
    input  data_t fill_data,
    input  logic  pop,
    input  logic  flush,
    output addr_t head_addr,
    output logic  head_filled,
    output data_t head_data,
    output cnt_t  allocated,
    output cnt_t  outstanding
);

    addr_t                  addr_mem [QUEUE_DEPTH];
    data_t                  data_mem [QUEUE_DEPTH];
    logic [QUEUE_DEPTH-1:0] filled_q;

    ptr_t alloc_ptr;
    ptr_t alloc_ptr_nxt;
    ptr_t fill_ptr;    // Oldest unfilled entry
    ptr_t pop_ptr;     // Queue head
    cnt_t alloc_cnt;   // Live entries, filled or not
    cnt_t pend_cnt;    // Live entries still waiting for data
    cnt_t drain_cnt;   // Fills still due for dropped entries
    logic fill_live;

    // Dropped entries were allocated first, so their fills come first
    assign fill_live     = fill_valid && (drain_cnt == '0);
    assign alloc_ptr_nxt = alloc_valid ? ptr_t'(alloc_ptr + 1'b1) : alloc_ptr;

    // Payload storage
    always_ff @(posedge clk) begin
        if (alloc_valid) begin
            addr_mem[alloc_ptr] <= alloc_addr;
        end
        if (fill_live) begin
            data_mem[fill_ptr] <= fill_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            alloc_ptr <= '0;
            fill_ptr  <= '0;
            pop_ptr   <= '0;
            alloc_cnt <= '0;
            pend_cnt  <= '0;
            drain_cnt <= '0;
            filled_q  <= '0;
        end else begin
            alloc_ptr <= alloc_ptr_nxt;
            if (alloc_valid) begin
                filled_q[alloc_ptr] <= 1'b0;
            end
            if (fill_live) begin
                filled_q[fill_ptr] <= 1'b1;
            end

            if (flush) begin
                // Everything live is dropped, unfilled entries turn into drain
                pop_ptr   <= alloc_ptr_nxt;
                fill_ptr  <= alloc_ptr_nxt;
                alloc_cnt <= '0;
                pend_cnt  <= '0;
                drain_cnt <= drain_cnt + pend_cnt + cnt_t'(alloc_valid)
                             - cnt_t'(fill_valid);
            end else begin
                if (pop) begin
                    pop_ptr <= pop_ptr + 1'b1;
                end
                if (fill_live) begin
                    fill_ptr <= fill_ptr + 1'b1;
                end
                if (fill_valid && !fill_live) begin
                    drain_cnt <= drain_cnt - 1'b1;   // Stale fill discarded
                end
                alloc_cnt <= alloc_cnt + cnt_t'(alloc_valid) - cnt_t'(pop);
                pend_cnt  <= pend_cnt + cnt_t'(alloc_valid) - cnt_t'(fill_live);
            end
        end
    end

    assign head_addr   = addr_mem[pop_ptr];
    assign head_data   = data_mem[pop_ptr];
    assign head_filled = (alloc_cnt != '0) && filled_q[pop_ptr];
    assign allocated   = alloc_cnt;
    assign outstanding = pend_cnt + drain_cnt;

endmodule

// ==== verilog/prefetch_regs.sv ====
// ====================
// APB control registers for the prefetch window,
// outstanding limit and enable
// ====================
`timescale 1ns/1ps

module prefetch_regs
    import prefetch_pkg::*;
(
    input  logic          clk,
    input  logic          arst_n,
    input  logic          psel,
    input  logic          penable,
    input  logic          pwrite,
    input  addr_t         paddr,
    input  data_t         pwdata,
    output data_t         prdata,
    output logic          pready,
    output logic          pslverr,
    output prefetch_cfg_t cfg
);

    prefetch_cfg_t cfg_q;
    logic          addr_hit;
    logic          wr_en;
    cnt_t          lim_clamped;

    assign addr_hit = (paddr == REG_BAR) || (paddr == REG_LIMIT) ||
                      (paddr == REG_OUT_LIMIT) || (paddr == REG_CTRL);
    assign wr_en    = psel && penable && pwrite && addr_hit;
    assign pready   = 1'b1;   // Zero wait states
    assign pslverr  = psel && penable && !addr_hit;
    assign cfg      = cfg_q;

    // Keep out_limit inside 1..QUEUE_DEPTH
    always_comb begin
        if (pwdata == '0) begin
            lim_clamped = cnt_t'(1);
        end else if (pwdata > QUEUE_DEPTH) begin
            lim_clamped = cnt_t'(QUEUE_DEPTH);
        end else begin
            lim_clamped = pwdata[CNT_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cfg_q.bar       <= '0;
            cfg_q.limit     <= '0;
            cfg_q.out_limit <= cnt_t'(QUEUE_DEPTH);
            cfg_q.enable    <= 1'b0;
        end else if (wr_en) begin
            case (paddr)
                REG_BAR:       cfg_q.bar       <= pwdata;
                REG_LIMIT:     cfg_q.limit     <= pwdata;
                REG_OUT_LIMIT: cfg_q.out_limit <= lim_clamped;
                REG_CTRL:      cfg_q.enable    <= pwdata[0];
                default:       cfg_q.enable    <= cfg_q.enable;
            endcase
        end
    end

    // Read-back mux
    always_comb begin
        case (paddr)
            REG_BAR:       prdata = data_t'(cfg_q.bar);
            REG_LIMIT:     prdata = data_t'(cfg_q.limit);
            REG_OUT_LIMIT: prdata = data_t'(cfg_q.out_limit);
            REG_CTRL:      prdata = data_t'(cfg_q.enable);
            default:       prdata = '0;
        endcase
    end

endmodule

// ==== verilog/prefetcher_top.sv ====
// ====================
// Sequential read prefetcher, window decode and
// AR, R and AW routing around the controller
// ====================
`timescale 1ns/1ps

module prefetcher_top
    import prefetch_pkg::*;
(
    input  logic  clk,
    input  logic  arst_n,
    // APB register port
    input  logic  psel,
    input  logic  penable,
    input  logic  pwrite,
    input  addr_t paddr,
    input  data_t pwdata,
    output data_t prdata,
    output logic  pready,
    output logic  pslverr,
    // Upstream side
    input  logic  s_ar_valid,
    output logic  s_ar_ready,
    input  ar_t   s_ar,
    output logic  s_r_valid,
    input  logic  s_r_ready,
    output r_t    s_r,
    input  logic  s_aw_valid,
    output logic  s_aw_ready,
    input  aw_t   s_aw,
    // Memory side
    output logic  m_ar_valid,
    input  logic  m_ar_ready,
    output ar_t   m_ar,
    input  logic  m_r_valid,
    output logic  m_r_ready,
    input  r_t    m_r,
    output logic  m_aw_valid,
    input  logic  m_aw_ready,
    output aw_t   m_aw
);

    prefetch_cfg_t cfg;
    logic  ar_in_win, aw_in_win;
    logic  wr_flush, aw_hold;
    logic  ctrl_s_ar_valid, ctrl_s_ar_ready;
    logic  ctrl_m_ar_valid, ctrl_m_ar_ready, ctrl_ar_grant;
    ar_t   ctrl_m_ar;
    logic  ctrl_s_r_valid, ctrl_s_r_ready, ctrl_r_grant;
    r_t    ctrl_s_r;
    logic  byp_ar_valid, byp_r_valid, r_is_pf;
    logic  ar_lock_q, r_lock_q;   // Bypass beat waiting on the shared port
    logic  alloc_valid, fill_valid, pop, flush;
    addr_t alloc_addr, head_addr;
    logic  head_filled;
    data_t head_data;
    cnt_t  allocated, outstanding;

    prefetch_regs regs_i (
        .clk(clk), .arst_n(arst_n),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .cfg(cfg)
    );

    prefetch_ctrl ctrl_i (
        .clk(clk), .arst_n(arst_n), .cfg(cfg),
        .s_ar_valid(ctrl_s_ar_valid), .s_ar(s_ar), .s_ar_ready(ctrl_s_ar_ready),
        .s_r_valid(ctrl_s_r_valid), .s_r(ctrl_s_r), .s_r_ready(ctrl_s_r_ready),
        .m_ar_valid(ctrl_m_ar_valid), .m_ar(ctrl_m_ar), .m_ar_ready(ctrl_m_ar_ready),
        .wr_flush(wr_flush), .aw_hold(aw_hold),
        .alloc_valid(alloc_valid), .alloc_addr(alloc_addr), .pop(pop), .flush(flush),
        .head_addr(head_addr), .head_filled(head_filled), .head_data(head_data),
        .allocated(allocated), .outstanding(outstanding)
    );

    prefetch_queue queue_i (
        .clk(clk), .arst_n(arst_n),
        .alloc_valid(alloc_valid), .alloc_addr(alloc_addr),
        .fill_valid(fill_valid), .fill_data(m_r.data),
        .pop(pop), .flush(flush),
        .head_addr(head_addr), .head_filled(head_filled), .head_data(head_data),
        .allocated(allocated), .outstanding(outstanding)
    );

    // Window test
    assign ar_in_win = cfg.enable && (s_ar.addr >= cfg.bar) && (s_ar.addr <= cfg.limit);
    assign aw_in_win = cfg.enable && (s_aw.addr >= cfg.bar) && (s_aw.addr <= cfg.limit);

    // AR channel, controller first unless a bypass read is already waiting
    assign ctrl_s_ar_valid = s_ar_valid && ar_in_win;
    assign byp_ar_valid    = s_ar_valid && !ar_in_win;
    assign ctrl_ar_grant   = ctrl_m_ar_valid && !ar_lock_q;
    assign ctrl_m_ar_ready = m_ar_ready && !ar_lock_q;
    assign m_ar_valid      = ctrl_ar_grant || byp_ar_valid;
    assign m_ar            = ctrl_ar_grant ? ctrl_m_ar : s_ar;
    assign s_ar_ready      = ar_in_win ? ctrl_s_ar_ready : (m_ar_ready && !ctrl_ar_grant);

    // R channel, prefetch data always goes to the queue
    assign r_is_pf        = (m_r.id == PF_ID);
    assign fill_valid     = m_r_valid && r_is_pf;
    assign byp_r_valid    = m_r_valid && !r_is_pf;
    assign ctrl_r_grant   = ctrl_s_r_valid && !r_lock_q;
    assign ctrl_s_r_ready = s_r_ready && !r_lock_q;
    assign s_r_valid      = ctrl_r_grant || byp_r_valid;
    assign s_r            = ctrl_r_grant ? ctrl_s_r : m_r;
    assign m_r_ready      = r_is_pf || (s_r_ready && !ctrl_r_grant);

    // AW channel
    assign wr_flush   = s_aw_valid && aw_in_win;
    assign m_aw_valid = s_aw_valid && !aw_hold;
    assign s_aw_ready = m_aw_ready && !aw_hold;
    assign m_aw       = s_aw;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ar_lock_q <= 1'b0;
            r_lock_q  <= 1'b0;
        end else begin
            ar_lock_q <= byp_ar_valid && !ctrl_ar_grant && !m_ar_ready;
            r_lock_q  <= byp_r_valid && !ctrl_r_grant && !s_r_ready;
        end
    end

endmodule
